/* Makefile */
# Verilator build and run for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= NO ERRORS

SOURCES := $(shell cat $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* axi_arbiter.sv */
/*
 * axi_arbiter
 * two masters (fetch read, data read/write) onto one AXI-lite slave
 * fixed priority: data write, data read, fetch read
 * one transaction in flight, request captured on grant and replayed
 * to the slave, response steered back to the owner combinationally
 */
`timescale 1ns/1ns

module axi_arbiter #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
) (
	input  logic     clk,
	input  logic     rst,
	axi_rd_if.slave  inst_s,
	axi_rd_if.slave  data_rd_s,
	axi_wr_if.slave  data_wr_s,
	axi_rd_if.master mem_rd_m,
	axi_wr_if.master mem_wr_m
);
	import axi_pkg::*;

	localparam int STRB_W = DATA_W / 8;

	arb_state_e state, state_nxt;
	logic is_wr;    // current data transaction is a write
	logic req_pend; // captured request not yet taken by the slave

	logic [ADDR_W-1:0] addr_q;
	logic [DATA_W-1:0] wdata_q;
	logic [STRB_W-1:0] strb_q;

	logic wr_req, rd_req, inst_req;
	logic grant_wr, grant_rd, grant_inst;
	logic mem_acc;
	logic rsp_done;

	// a write needs address and data together
	assign wr_req   = data_wr_s.aw_valid & data_wr_s.w_valid;
	assign rd_req   = data_rd_s.ar_valid;
	assign inst_req = inst_s.ar_valid;

	assign grant_wr   = (state == IDLE) & wr_req;
	assign grant_rd   = (state == IDLE) & ~wr_req & rd_req;
	assign grant_inst = (state == IDLE) & ~wr_req & ~rd_req & inst_req;

	// ready only in the grant cycle
	assign data_wr_s.aw_ready = grant_wr;
	assign data_wr_s.w_ready  = grant_wr;
	assign data_rd_s.ar_ready = grant_rd;
	assign inst_s.ar_ready    = grant_inst;

	assign mem_acc = (mem_rd_m.ar_valid & mem_rd_m.ar_ready) |
	                 (mem_wr_m.aw_valid & mem_wr_m.aw_ready);

	// replay of the captured request
	assign mem_rd_m.ar_addr  = addr_q;
	assign mem_rd_m.ar_valid = req_pend & ~is_wr;
	assign mem_wr_m.aw_addr  = addr_q;
	assign mem_wr_m.aw_valid = req_pend & is_wr;
	assign mem_wr_m.w_data   = wdata_q;
	assign mem_wr_m.w_strb   = strb_q;
	assign mem_wr_m.w_valid  = req_pend & is_wr;

	// response steering, payload passes straight through
	assign data_wr_s.b_resp  = mem_wr_m.b_resp;
	assign data_wr_s.b_valid = (state == BUSY_DATA) & is_wr & mem_wr_m.b_valid;
	assign mem_wr_m.b_ready  = (state == BUSY_DATA) & is_wr & data_wr_s.b_ready;

	assign data_rd_s.r_data  = mem_rd_m.r_data;
	assign data_rd_s.r_resp  = mem_rd_m.r_resp;
	assign data_rd_s.r_valid = (state == BUSY_DATA) & ~is_wr & mem_rd_m.r_valid;

	assign inst_s.r_data  = mem_rd_m.r_data;
	assign inst_s.r_resp  = mem_rd_m.r_resp;
	assign inst_s.r_valid = (state == BUSY_INST) & mem_rd_m.r_valid;

	assign mem_rd_m.r_ready = ((state == BUSY_DATA) & ~is_wr & data_rd_s.r_ready) |
	                          ((state == BUSY_INST) & inst_s.r_ready);

	// owner takes the response, any resp code ends the transaction
	assign rsp_done = (data_wr_s.b_valid & data_wr_s.b_ready) |
	                  (data_rd_s.r_valid & data_rd_s.r_ready) |
	                  (inst_s.r_valid & inst_s.r_ready);

	always_comb begin
		state_nxt = state;
		unique case (state)
			IDLE: begin
				if (grant_wr | grant_rd) begin
					state_nxt = BUSY_DATA;
				end else if (grant_inst) begin
					state_nxt = BUSY_INST;
				end
			end
			BUSY_DATA, BUSY_INST: begin
				if (rsp_done) begin
					state_nxt = IDLE; // next grant one cycle later
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			is_wr    <= 1'b0;
			req_pend <= 1'b0;
		end else begin
			state <= state_nxt;
			if (grant_wr | grant_rd | grant_inst) begin
				is_wr    <= grant_wr;
				req_pend <= 1'b1;
			end else if (mem_acc) begin
				req_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (grant_wr) begin
			addr_q  <= data_wr_s.aw_addr;
			wdata_q <= data_wr_s.w_data;
			strb_q  <= data_wr_s.w_strb;
		end else if (grant_rd) begin
			addr_q <= data_rd_s.ar_addr;
		end else if (grant_inst) begin
			addr_q <= inst_s.ar_addr;
		end
	end

	// one transaction in flight, a new grant finds the last request taken
	a_one_in_flight: assert property (@(posedge clk) disable iff (rst)
		(inst_s.ar_ready || data_rd_s.ar_ready || data_wr_s.aw_ready) |-> !req_pend);

	// the slave only answers a request that this arbiter handed over
	a_no_rsp_idle: assert property (@(posedge clk) disable iff (rst)
		(state == IDLE) |-> !(mem_rd_m.r_valid || mem_wr_m.b_valid));

endmodule

/* axi_if.sv */
/*
 * axi_rd_if / axi_wr_if
 * AXI-lite read and write channel bundles, no IDs and no bursts
 * master drives address, payload and response ready,
 * slave drives the address ready and the response
 */
`timescale 1ns/1ns

interface axi_rd_if #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
);
	import axi_pkg::*;

	logic [ADDR_W-1:0] ar_addr;
	logic              ar_valid;
	logic              ar_ready;

	logic [DATA_W-1:0] r_data;
	resp_e             r_resp;
	logic              r_valid;
	logic              r_ready;

	modport master (
		output ar_addr, ar_valid, r_ready,
		input  ar_ready, r_data, r_resp, r_valid
	);

	modport slave (
		input  ar_addr, ar_valid, r_ready,
		output ar_ready, r_data, r_resp, r_valid
	);
endinterface

interface axi_wr_if #(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
);
	import axi_pkg::*;

	localparam int STRB_W = DATA_W / 8; // one strobe bit per byte lane

	logic [ADDR_W-1:0] aw_addr;
	logic              aw_valid;
	logic              aw_ready;

	logic [DATA_W-1:0] w_data;
	logic [STRB_W-1:0] w_strb;
	logic              w_valid;
	logic              w_ready;

	resp_e             b_resp;
	logic              b_valid;
	logic              b_ready;

	modport master (
		output aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
		input  aw_ready, w_ready, b_resp, b_valid
	);

	modport slave (
		input  aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready,
		output aw_ready, w_ready, b_resp, b_valid
	);
endinterface

/* axi_pkg.sv */
/*
 * axi_pkg
 * shared encodings for the core memory subsystem: the AXI-lite
 * response code and the arbiter FSM states
 */
package axi_pkg;

	// response code on the r and b channels, EXOKAY and DECERR never produced
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} resp_e;

	// arbiter FSM
	typedef enum logic [1:0] {
		IDLE      = 2'b00, // waiting for a request
		BUSY_DATA = 2'b01, // data port owns the SRAM
		BUSY_INST = 2'b10  // fetch port owns the SRAM
	} arb_state_e;

endpackage

/* axi_sram.sv */
/*
 * axi_sram
 * single-ported word array behind AXI-lite read and write channels
 * response valid SRAM_LATENCY cycles after the address is taken,
 * byte strobes on writes, SLVERR past the end of the array
 */
`timescale 1ns/1ns

module axi_sram #(
	parameter int ADDR_W       = 32,
	parameter int DATA_W       = 32,
	parameter int MEM_WORDS    = 256,
	parameter int SRAM_LATENCY = 2
) (
	input  logic    clk,
	input  logic    rst,
	axi_rd_if.slave rd_s,
	axi_wr_if.slave wr_s
);
	import axi_pkg::*;

	localparam int STRB_W    = DATA_W / 8;
	localparam int OFS_W     = $clog2(STRB_W);
	localparam int IDX_W     = $clog2(MEM_WORDS);
	localparam int CNT_W     = $clog2(SRAM_LATENCY + 1);
	localparam int MEM_BYTES = MEM_WORDS * STRB_W;

	logic [DATA_W-1:0] mem [MEM_WORDS];

	logic             busy;  // from accept until response taken
	logic             is_wr;
	logic [CNT_W-1:0] cnt;   // cycles left until response valid
	logic             rsp_rdy;

	logic [DATA_W-1:0] rdata_q;
	resp_e             resp_q;

	logic             wr_go, rd_go;
	logic             wr_ok, rd_ok;
	logic [IDX_W-1:0] wr_idx, rd_idx;

	assign wr_go = ~busy & wr_s.aw_valid & wr_s.w_valid;
	assign rd_go = ~busy & rd_s.ar_valid & ~(wr_s.aw_valid & wr_s.w_valid);

	assign wr_ok  = wr_s.aw_addr < MEM_BYTES;
	assign rd_ok  = rd_s.ar_addr < MEM_BYTES;
	assign wr_idx = wr_s.aw_addr[OFS_W +: IDX_W];
	assign rd_idx = rd_s.ar_addr[OFS_W +: IDX_W];

	assign wr_s.aw_ready = ~busy;
	assign wr_s.w_ready  = ~busy;
	assign rd_s.ar_ready = ~busy & ~(wr_s.aw_valid & wr_s.w_valid); // write wins

	assign rsp_rdy = busy & (cnt == '0);

	assign rd_s.r_valid = rsp_rdy & ~is_wr;
	assign rd_s.r_data  = rdata_q;
	assign rd_s.r_resp  = resp_q;
	assign wr_s.b_valid = rsp_rdy & is_wr;
	assign wr_s.b_resp  = resp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy  <= 1'b0;
			is_wr <= 1'b0;
			cnt   <= '0;
		end else if (wr_go | rd_go) begin
			busy  <= 1'b1;
			is_wr <= wr_go;
			cnt   <= CNT_W'(SRAM_LATENCY);
		end else if (busy) begin
			if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else if ((rd_s.r_valid & rd_s.r_ready) | (wr_s.b_valid & wr_s.b_ready)) begin
				busy <= 1'b0;
			end
		end
	end

	// array and response payload
	always_ff @(posedge clk) begin
		if (wr_go) begin
			resp_q <= wr_ok ? OKAY : SLVERR;
			if (wr_ok) begin
				for (int b = 0; b < STRB_W; b++) begin
					if (wr_s.w_strb[b]) begin
						mem[wr_idx][8*b +: 8] <= wr_s.w_data[8*b +: 8];
					end
				end
			end
		end else if (rd_go) begin
			rdata_q <= rd_ok ? mem[rd_idx] : '0; // zero past the end
			resp_q  <= rd_ok ? OKAY : SLVERR;
		end
	end

	a_r_stable: assert property (@(posedge clk) disable iff (rst)
		rd_s.r_valid && !rd_s.r_ready |=>
		rd_s.r_valid && $stable(rd_s.r_data) && $stable(rd_s.r_resp));

	a_b_stable: assert property (@(posedge clk) disable iff (rst)
		wr_s.b_valid && !wr_s.b_ready |=> wr_s.b_valid && $stable(wr_s.b_resp));

endmodule

/* filelist.f */
axi_pkg.sv
axi_if.sv
axi_arbiter.sv
axi_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* mem_subsys_top.sv */
/*
 * mem_subsys_top
 * memory side of the core: fetch and data ports on plain pins,
 * bundled into AXI-lite interfaces, arbitrated onto one SRAM
 */
`timescale 1ns/1ns

module mem_subsys_top #(
	parameter int ADDR_W       = 32,
	parameter int DATA_W       = 32,
	parameter int MEM_WORDS    = 256,
	parameter int SRAM_LATENCY = 2
) (
	input  logic                  clk,
	input  logic                  rst,

	// instruction fetch, read only
	input  logic [ADDR_W-1:0]     inst_ar_addr_i,
	input  logic                  inst_ar_valid_i,
	output logic                  inst_ar_ready_o,
	output logic [DATA_W-1:0]     inst_r_data_o,
	output axi_pkg::resp_e        inst_r_resp_o,
	output logic                  inst_r_valid_o,
	input  logic                  inst_r_ready_i,

	// data read
	input  logic [ADDR_W-1:0]     data_ar_addr_i,
	input  logic                  data_ar_valid_i,
	output logic                  data_ar_ready_o,
	output logic [DATA_W-1:0]     data_r_data_o,
	output axi_pkg::resp_e        data_r_resp_o,
	output logic                  data_r_valid_o,
	input  logic                  data_r_ready_i,

	// data write
	input  logic [ADDR_W-1:0]     data_aw_addr_i,
	input  logic                  data_aw_valid_i,
	output logic                  data_aw_ready_o,
	input  logic [DATA_W-1:0]     data_w_data_i,
	input  logic [DATA_W/8-1:0]   data_w_strb_i,
	input  logic                  data_w_valid_i,
	output logic                  data_w_ready_o,
	output axi_pkg::resp_e        data_b_resp_o,
	output logic                  data_b_valid_o,
	input  logic                  data_b_ready_i
);

	axi_rd_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) inst_rd ();
	axi_rd_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) data_rd ();
	axi_wr_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) data_wr ();
	axi_rd_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_rd ();
	axi_wr_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_wr ();

	// fetch port pins
	assign inst_rd.ar_addr  = inst_ar_addr_i;
	assign inst_rd.ar_valid = inst_ar_valid_i;
	assign inst_rd.r_ready  = inst_r_ready_i;
	assign inst_ar_ready_o  = inst_rd.ar_ready;
	assign inst_r_data_o    = inst_rd.r_data;
	assign inst_r_resp_o    = inst_rd.r_resp;
	assign inst_r_valid_o   = inst_rd.r_valid;

	// data read pins
	assign data_rd.ar_addr  = data_ar_addr_i;
	assign data_rd.ar_valid = data_ar_valid_i;
	assign data_rd.r_ready  = data_r_ready_i;
	assign data_ar_ready_o  = data_rd.ar_ready;
	assign data_r_data_o    = data_rd.r_data;
	assign data_r_resp_o    = data_rd.r_resp;
	assign data_r_valid_o   = data_rd.r_valid;

	// data write pins
	assign data_wr.aw_addr  = data_aw_addr_i;
	assign data_wr.aw_valid = data_aw_valid_i;
	assign data_wr.w_data   = data_w_data_i;
	assign data_wr.w_strb   = data_w_strb_i;
	assign data_wr.w_valid  = data_w_valid_i;
	assign data_wr.b_ready  = data_b_ready_i;
	assign data_aw_ready_o  = data_wr.aw_ready;
	assign data_w_ready_o   = data_wr.w_ready;
	assign data_b_resp_o    = data_wr.b_resp;
	assign data_b_valid_o   = data_wr.b_valid;

	axi_arbiter #(
		.ADDR_W (ADDR_W),
		.DATA_W (DATA_W)
	) u_arbiter (
		.clk       (clk),
		.rst       (rst),
		.inst_s    (inst_rd),
		.data_rd_s (data_rd),
		.data_wr_s (data_wr),
		.mem_rd_m  (mem_rd),
		.mem_wr_m  (mem_wr)
	);

	axi_sram #(
		.ADDR_W       (ADDR_W),
		.DATA_W       (DATA_W),
		.MEM_WORDS    (MEM_WORDS),
		.SRAM_LATENCY (SRAM_LATENCY)
	) u_sram (
		.clk  (clk),
		.rst  (rst),
		.rd_s (mem_rd),
		.wr_s (mem_wr)
	);

endmodule

/* tb_mem_subsys.sv */
/*
 * tb_mem_subsys
 * table-driven testbench for the memory subsystem: data writes and reads,
 * fetch reads, out-of-range accesses and a fetch/data collision, with
 * random response stalls and a shadow copy of the SRAM
 */
`timescale 1ns/1ns

module tb_mem_subsys;
	import axi_pkg::*;

	localparam int TIMEOUT = 50; // cycles per wait loop

	typedef enum int {K_INST, K_DRD, K_DWR, K_BOTH} kind_e;
	typedef struct {
		string       name;
		kind_e       kind;
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		resp_e       resp;
	} test_t;

	logic clk = 1'b0;
	logic rst = 1'b1;
	logic [31:0] inst_ar_addr, inst_r_data, data_ar_addr, data_r_data;
	logic [31:0] data_aw_addr, data_w_data;
	logic [3:0]  data_w_strb;
	logic inst_ar_valid, inst_ar_ready, inst_r_valid, inst_r_ready;
	logic data_ar_valid, data_ar_ready, data_r_valid, data_r_ready;
	logic data_aw_valid, data_aw_ready, data_w_valid, data_w_ready, data_b_valid, data_b_ready;
	resp_e inst_r_resp, data_r_resp, data_b_resp;

	test_t       tests[$];
	logic [31:0] shadow [256];
	logic [7:0]  lfsr = 8'd72;
	int          errors = 0;
	logic        timed_out = 1'b0;
	logic        watch_order = 1'b0; // data read of a collision still open
	logic        order_bad = 1'b0;

	mem_subsys_top #(.ADDR_W(32), .DATA_W(32), .MEM_WORDS(256), .SRAM_LATENCY(2)) dut (
		.clk(clk), .rst(rst),
		.inst_ar_addr_i(inst_ar_addr), .inst_ar_valid_i(inst_ar_valid),
		.inst_ar_ready_o(inst_ar_ready), .inst_r_data_o(inst_r_data),
		.inst_r_resp_o(inst_r_resp), .inst_r_valid_o(inst_r_valid),
		.inst_r_ready_i(inst_r_ready),
		.data_ar_addr_i(data_ar_addr), .data_ar_valid_i(data_ar_valid),
		.data_ar_ready_o(data_ar_ready), .data_r_data_o(data_r_data),
		.data_r_resp_o(data_r_resp), .data_r_valid_o(data_r_valid),
		.data_r_ready_i(data_r_ready),
		.data_aw_addr_i(data_aw_addr), .data_aw_valid_i(data_aw_valid),
		.data_aw_ready_o(data_aw_ready), .data_w_data_i(data_w_data),
		.data_w_strb_i(data_w_strb), .data_w_valid_i(data_w_valid),
		.data_w_ready_o(data_w_ready), .data_b_resp_o(data_b_resp),
		.data_b_valid_o(data_b_valid), .data_b_ready_i(data_b_ready)
	);

	always #20 clk = ~clk;

	// fetch must stay silent while the data read of a collision is open
	always @(negedge clk) begin
		if (watch_order && (inst_r_valid || inst_ar_ready)) begin
			order_bad = 1'b1;
		end
	end

	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]}; // x^8+x^6+x^5+x^4+1
	endfunction

	task automatic pick_stall(output int n);
		n = 0;
		repeat (2) begin
			n = n * 2 + int'(lfsr[7]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// word at an address as the strobe and range rules leave it
	function automatic logic [31:0] expect_data(input logic [31:0] addr);
		return (addr < 32'h400) ? shadow[addr[9:2]] : 32'h0;
	endfunction

	function automatic logic grant_seen(input kind_e port);
		case (port)
			K_INST:  return inst_ar_ready;
			K_DRD:   return data_ar_ready;
			default: return data_aw_ready & data_w_ready;
		endcase
	endfunction

	function automatic logic [34:0] rsp_word(input kind_e port); // {valid, resp, data}
		case (port)
			K_INST:  return {inst_r_valid, inst_r_resp, inst_r_data};
			K_DRD:   return {data_r_valid, data_r_resp, data_r_data};
			default: return {data_b_valid, data_b_resp, 32'h0};
		endcase
	endfunction

	task automatic set_rsp_ready(input kind_e port, input logic v);
		case (port)
			K_INST:  inst_r_ready <= v;
			K_DRD:   data_r_ready <= v;
			default: data_b_ready <= v;
		endcase
	endtask

	task automatic wait_grant(input kind_e port, output logic ok);
		int n;
		n = 0;
		@(negedge clk);
		while (!grant_seen(port) && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		ok = grant_seen(port);
		if (!ok) begin
			$display("timeout: request on %s never granted, arbiter in %s",
				port.name(), dut.u_arbiter.state.name());
			timed_out = 1'b1;
			errors++;
		end
		@(posedge clk); // transfer edge
		case (port)
			K_INST: inst_ar_valid <= 1'b0;
			K_DRD:  data_ar_valid <= 1'b0;
			default: begin
				data_aw_valid <= 1'b0;
				data_w_valid  <= 1'b0;
			end
		endcase
	endtask

	task automatic take_rsp(input kind_e port, output logic [31:0] data, output resp_e resp,
		output logic ok);
		logic [34:0] first;
		logic        stable;
		int          stall;
		int          n;
		n = 0;
		@(negedge clk);
		first = rsp_word(port);
		while (!first[34] && n < TIMEOUT) begin
			@(negedge clk);
			first = rsp_word(port);
			n++;
		end
		data = first[31:0];
		resp = resp_e'(first[33:32]);
		ok   = first[34];
		if (!ok) begin
			$display("timeout: no response on %s, arbiter in %s",
				port.name(), dut.u_arbiter.state.name());
			timed_out = 1'b1;
			errors++;
			return;
		end
		pick_stall(stall);
		stable = 1'b1;
		repeat (stall) begin
			@(negedge clk);
			if (rsp_word(port) !== first) stable = 1'b0;
		end
		@(posedge clk);
		set_rsp_ready(port, 1'b1);
		@(negedge clk);
		if (rsp_word(port) !== first) stable = 1'b0;
		@(posedge clk); // response handshake
		set_rsp_ready(port, 1'b0);
		if (!stable) begin
			$display("response on %s dropped or changed before it was accepted", port.name());
			errors++;
		end
	endtask

	task automatic run_test(input test_t t);
		logic        ok;
		logic [31:0] rdata;
		logic [31:0] exp;
		resp_e       rresp;
		kind_e       port;
		int          err0;
		err0 = errors;
		exp  = expect_data(t.addr);
		port = (t.kind == K_BOTH) ? K_DRD : t.kind;
		@(posedge clk);
		if (t.kind == K_DWR) begin
			data_aw_addr  <= t.addr;
			data_w_data   <= t.data;
			data_w_strb   <= t.strb;
			data_aw_valid <= 1'b1;
			data_w_valid  <= 1'b1;
		end
		if (t.kind == K_DRD || t.kind == K_BOTH) begin
			data_ar_addr  <= t.addr;
			data_ar_valid <= 1'b1;
		end
		if (t.kind == K_INST || t.kind == K_BOTH) begin
			inst_ar_addr  <= t.addr;
			inst_ar_valid <= 1'b1;
		end
		watch_order = (t.kind == K_BOTH);
		order_bad   = 1'b0;
		wait_grant(port, ok);
		if (ok) take_rsp(port, rdata, rresp, ok);
		watch_order = 1'b0;
		if (ok && t.kind == K_BOTH) begin
			if (order_bad) begin
				$display("%s: fetch was served before the data read finished", t.name);
				errors++;
			end
			if (rdata !== exp) begin
				$display("** Error %s: expected %h, actual %h", t.name, exp, rdata);
				errors++;
			end
			if (rresp !== t.resp) begin
				$display("** Error %s: expected %s, actual %s", t.name, t.resp.name(), rresp.name());
				errors++;
			end
			port = K_INST; // fetch is still waiting
			wait_grant(port, ok);
			if (ok) take_rsp(port, rdata, rresp, ok);
		end
		if (ok && port != K_DWR && rdata !== exp) begin
			$display("** Error %s: expected %h, actual %h", t.name, exp, rdata);
			errors++;
		end
		if (ok && rresp !== t.resp) begin
			$display("** Error %s: expected %s, actual %s", t.name, t.resp.name(), rresp.name());
			errors++;
		end
		if (t.kind == K_DWR && t.addr < 32'h400) begin
			for (int b = 0; b < 4; b++) begin
				if (t.strb[b]) shadow[t.addr[9:2]][8*b +: 8] = t.data[8*b +: 8];
			end
		end
		$display("%-10s %s", t.name, (errors == err0) ? "passed" : "failed");
	endtask

	task automatic add_test(input string name, input kind_e kind, input logic [31:0] addr,
		input logic [31:0] data, input logic [3:0] strb, input resp_e resp);
		test_t t;
		t.name = name;
		t.kind = kind;
		t.addr = addr;
		t.data = data;
		t.strb = strb;
		t.resp = resp;
		tests.push_back(t);
	endtask

	initial begin
		logic [6:0] idle_flags;
		int         n_run;
		{inst_ar_addr, inst_ar_valid, inst_r_ready, data_ar_addr, data_ar_valid} = '0;
		{data_r_ready, data_aw_addr, data_aw_valid, data_w_data, data_w_strb} = '0;
		{data_w_valid, data_b_ready} = '0;
		add_test("wr_zero",   K_DWR,  32'h0000_0000, 32'h0bad_c0de, 4'hf, OKAY);
		add_test("wr_word",   K_DWR,  32'h0000_0010, 32'hdead_beef, 4'hf, OKAY);
		add_test("rd_word",   K_DRD,  32'h0000_0010, 32'h0,         4'h0, OKAY);
		add_test("wr_bytes",  K_DWR,  32'h0000_0010, 32'h1122_3344, 4'h5, OKAY);
		add_test("rd_bytes",  K_DRD,  32'h0000_0010, 32'h0,         4'h0, OKAY);
		add_test("wr_top",    K_DWR,  32'h0000_0010, 32'haabb_ccdd, 4'h8, OKAY);
		add_test("rd_top",    K_DRD,  32'h0000_0010, 32'h0,         4'h0, OKAY);
		add_test("wr_code",   K_DWR,  32'h0000_0040, 32'h0050_0093, 4'hf, OKAY);
		add_test("fetch",     K_INST, 32'h0000_0040, 32'h0,         4'h0, OKAY);
		add_test("wr_oor",    K_DWR,  32'h0000_0400, 32'hcafe_f00d, 4'hf, SLVERR);
		add_test("rd_oor",    K_DRD,  32'h0000_0400, 32'h0,         4'h0, SLVERR);
		add_test("fetch_oor", K_INST, 32'hffff_fffc, 32'h0,         4'h0, SLVERR);
		add_test("rd_zero",   K_DRD,  32'h0000_0000, 32'h0,         4'h0, OKAY); // no alias
		add_test("wr_last",   K_DWR,  32'h0000_03fc, 32'h5a5a_a5a5, 4'hf, OKAY);
		add_test("both_code", K_BOTH, 32'h0000_0040, 32'h0,         4'h0, OKAY);
		add_test("both_last", K_BOTH, 32'h0000_03fc, 32'h0,         4'h0, OKAY);
		add_test("both_oor",  K_BOTH, 32'h0000_0800, 32'h0,         4'h0, SLVERR);
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		idle_flags = {inst_ar_ready, inst_r_valid, data_ar_ready, data_r_valid,
			data_aw_ready, data_w_ready, data_b_valid};
		if (idle_flags !== 7'b0) begin
			$display("** Error reset_idle: expected %b, actual %b", 7'b0, idle_flags);
			errors++;
		end
		$display("%-10s %s", "reset_idle", (errors == 0) ? "passed" : "failed");
		n_run = 1;
		foreach (tests[i]) begin
			if (!timed_out) begin
				run_test(tests[i]);
				n_run++;
			end
		end
		$display("tests run %0d, errors %0d", n_run, errors);
		if (errors == 0 && !timed_out) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
